//--- common/sound_pkg.sv
package sound_pkg;

	typedef logic [9:0] freq_t; // half period in prescaled clocks, 0 is silence.
	typedef logic [5:0] note_cnt_t;

	typedef enum logic [4:0] {
		st_idle,
		st_hit_1, st_hit_2, st_hit_3,
		st_pickup_1, st_pickup_2, st_pickup_3,
		st_bird_1, st_bird_2, st_bird_3,
		st_lvl_1, st_lvl_2, st_lvl_3,
		st_shot_1, st_shot_2, st_shot_3
	} sfx_state_e;

	localparam note_cnt_t NOTE_FRAMES = 6'd32; // frames per note.

	localparam freq_t HIT_N1 = 10'h250;
	localparam freq_t HIT_N2 = 10'h2EA;
	localparam freq_t HIT_N3 = 10'h00F;

	localparam freq_t PICKUP_N1 = 10'h1F2;
	localparam freq_t PICKUP_N2 = 10'h250;
	localparam freq_t PICKUP_N3 = 10'h1BB;

	localparam freq_t BIRD_N1 = 10'h20F;
	localparam freq_t BIRD_N2 = 10'h1D6;
	localparam freq_t BIRD_N3 = 10'h18B;

	localparam freq_t LVL_N = 10'h00F; // same note three times.

	localparam freq_t SHOT_N1 = 10'h2EA;
	localparam freq_t SHOT_N2 = 10'h1F2;
	localparam freq_t SHOT_N3 = 10'h00F;

endpackage

//--- common/apb_pkg.sv
package apb_pkg;

	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// register map.
	localparam apb_addr_t ADDR_TRIG = 8'h00; // write only, event bits 4:0.
	localparam apb_addr_t ADDR_CTRL = 8'h04; // bit 0 mute.
	localparam apb_addr_t ADDR_STATUS = 8'h08; // read only.

	// trigger bit positions.
	localparam int TRIG_PLAYER_HIT = 0;
	localparam int TRIG_PICKUP = 1;
	localparam int TRIG_BIRD_HIT = 2;
	localparam int TRIG_LEVEL_UP = 3;
	localparam int TRIG_SHOT = 4;

endpackage

//--- common/sfx_event_if.sv
interface sfx_event_if;

	logic player_hit;
	logic pickup;
	logic bird_hit;
	logic level_up;
	logic shot;

	modport source (
		output player_hit, pickup, bird_hit, level_up, shot
	);

	modport sink (
		input player_hit, pickup, bird_hit, level_up, shot
	);

endinterface

//--- hw/apb_sound_regs.sv
module apb_sound_regs (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_addr_t paddr,
	input apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pslverr,
	sfx_event_if.source ev,
	input sound_pkg::freq_t freq,
	input logic sound_en,
	output logic mute
);

	logic access;
	logic is_trig;
	logic is_ctrl;
	logic is_status;
	logic bad_access;
	logic trig_wr;
	logic ctrl_wr;
	logic [4:0] ev_q;

	assign access = psel && penable;
	assign is_trig = (paddr == apb_pkg::ADDR_TRIG);
	assign is_ctrl = (paddr == apb_pkg::ADDR_CTRL);
	assign is_status = (paddr == apb_pkg::ADDR_STATUS);

	// unmapped address, status write or trigger read.
	assign bad_access = !(is_trig || is_ctrl || is_status) ||
		(pwrite && is_status) || (!pwrite && is_trig);

	assign pslverr = access && bad_access;
	assign trig_wr = access && pwrite && is_trig;
	assign ctrl_wr = access && pwrite && is_ctrl;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ev_q <= '0;
			mute <= 1'b0;
		end
		else begin
			ev_q <= trig_wr ? pwdata[4:0] : 5'b0; // one cycle pulses.
			if (ctrl_wr) begin
				mute <= pwdata[0];
			end
		end
	end

	assign ev.player_hit = ev_q[apb_pkg::TRIG_PLAYER_HIT];
	assign ev.pickup = ev_q[apb_pkg::TRIG_PICKUP];
	assign ev.bird_hit = ev_q[apb_pkg::TRIG_BIRD_HIT];
	assign ev.level_up = ev_q[apb_pkg::TRIG_LEVEL_UP];
	assign ev.shot = ev_q[apb_pkg::TRIG_SHOT];

	// read data is only driven during a read access.
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (is_ctrl) begin
				prdata[0] = mute;
			end
			else if (is_status) begin
				prdata[0] = sound_en;
				prdata[25:16] = freq;
			end
		end
	end

endmodule

//--- sound_machine/sound_machine.sv
module sound_machine (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	sfx_event_if.sink ev,
	output sound_pkg::freq_t freq,
	output logic sound_en
);

	sound_pkg::sfx_state_e state;
	sound_pkg::sfx_state_e next_state;
	sound_pkg::note_cnt_t frame_cnt;
	logic [4:0] pending;
	logic [4:0] ev_bits;
	logic note_done;
	logic advance;

	assign ev_bits = {ev.shot, ev.level_up, ev.bird_hit, ev.pickup, ev.player_hit};

	// ends on the tick after NOTE_FRAMES ticks were counted.
	assign note_done = frame_tick && (frame_cnt == sound_pkg::NOTE_FRAMES);
	assign advance = (state == sound_pkg::st_idle) ? (pending != 5'b0) : note_done;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= sound_pkg::st_idle;
			frame_cnt <= '0;
			pending <= '0;
		end
		else begin
			state <= next_state;
			// new pulses merge into the set, taken ones clear.
			pending <= advance ? ev_bits : (pending | ev_bits);
			if (advance) begin
				frame_cnt <= '0;
			end
			else if (frame_tick && (state != sound_pkg::st_idle)) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		if (advance) begin
			if (pending[0]) begin
				next_state = sound_pkg::st_hit_1;
			end
			else if (pending[1]) begin
				next_state = sound_pkg::st_pickup_1;
			end
			else if (pending[2]) begin
				next_state = sound_pkg::st_bird_1;
			end
			else if (pending[3]) begin
				next_state = sound_pkg::st_lvl_1;
			end
			else if (pending[4]) begin
				next_state = sound_pkg::st_shot_1;
			end
			else begin
				case (state)
					sound_pkg::st_hit_1: next_state = sound_pkg::st_hit_2;
					sound_pkg::st_hit_2: next_state = sound_pkg::st_hit_3;
					sound_pkg::st_pickup_1: next_state = sound_pkg::st_pickup_2;
					sound_pkg::st_pickup_2: next_state = sound_pkg::st_pickup_3;
					sound_pkg::st_bird_1: next_state = sound_pkg::st_bird_2;
					sound_pkg::st_bird_2: next_state = sound_pkg::st_bird_3;
					sound_pkg::st_lvl_1: next_state = sound_pkg::st_lvl_2;
					sound_pkg::st_lvl_2: next_state = sound_pkg::st_lvl_3;
					sound_pkg::st_shot_1: next_state = sound_pkg::st_shot_2;
					sound_pkg::st_shot_2: next_state = sound_pkg::st_shot_3;
					default: next_state = sound_pkg::st_idle; // after note 3.
				endcase
			end
		end
	end

	// note table.
	always_comb begin
		case (state)
			sound_pkg::st_hit_1: freq = sound_pkg::HIT_N1;
			sound_pkg::st_hit_2: freq = sound_pkg::HIT_N2;
			sound_pkg::st_hit_3: freq = sound_pkg::HIT_N3;
			sound_pkg::st_pickup_1: freq = sound_pkg::PICKUP_N1;
			sound_pkg::st_pickup_2: freq = sound_pkg::PICKUP_N2;
			sound_pkg::st_pickup_3: freq = sound_pkg::PICKUP_N3;
			sound_pkg::st_bird_1: freq = sound_pkg::BIRD_N1;
			sound_pkg::st_bird_2: freq = sound_pkg::BIRD_N2;
			sound_pkg::st_bird_3: freq = sound_pkg::BIRD_N3;
			sound_pkg::st_lvl_1,
			sound_pkg::st_lvl_2,
			sound_pkg::st_lvl_3: freq = sound_pkg::LVL_N;
			sound_pkg::st_shot_1: freq = sound_pkg::SHOT_N1;
			sound_pkg::st_shot_2: freq = sound_pkg::SHOT_N2;
			sound_pkg::st_shot_3: freq = sound_pkg::SHOT_N3;
			default: freq = '0;
		endcase
	end

	assign sound_en = (state != sound_pkg::st_idle);

endmodule

//--- hw/frame_timer.sv
module frame_timer #(
	parameter int FRAME_CLKS = 833333
) (
	input logic clk,
	input logic resetN,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(FRAME_CLKS + 1);

	logic [CNT_W-1:0] clk_cnt;
	logic wrap;

	assign wrap = (clk_cnt == CNT_W'(FRAME_CLKS - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			clk_cnt <= '0;
			frame_tick <= 1'b0;
		end
		else begin
			clk_cnt <= wrap ? '0 : clk_cnt + 1'b1;
			frame_tick <= wrap; // stands in for start of frame.
		end
	end

endmodule

//--- hw/tone_gen.sv
module tone_gen #(
	parameter int TONE_DIV = 50
) (
	input logic clk,
	input logic resetN,
	input sound_pkg::freq_t freq,
	input logic sound_en,
	input logic mute,
	output logic audio_out
);

	localparam int PRE_W = $clog2(TONE_DIV + 1);

	logic [PRE_W-1:0] pre_cnt;
	sound_pkg::freq_t half_cnt;
	sound_pkg::freq_t freq_q;
	logic tone_on;
	logic freq_chg;
	logic step;
	logic half_done;

	assign tone_on = sound_en && !mute && (freq != '0);
	assign freq_chg = (freq != freq_q);
	assign step = (pre_cnt == PRE_W'(TONE_DIV - 1));
	assign half_done = step && (half_cnt == sound_pkg::freq_t'(freq - 1'b1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pre_cnt <= '0;
			half_cnt <= '0;
			freq_q <= '0;
			audio_out <= 1'b0;
		end
		else begin
			freq_q <= freq;
			if (!tone_on) begin
				pre_cnt <= '0;
				half_cnt <= '0;
				audio_out <= 1'b0;
			end
			else if (freq_chg) begin
				pre_cnt <= '0; // restart the half period.
				half_cnt <= '0;
			end
			else begin
				pre_cnt <= step ? '0 : pre_cnt + 1'b1;
				if (half_done) begin
					half_cnt <= '0;
					audio_out <= !audio_out;
				end
				else if (step) begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/sound_top.sv
module sound_top #(
	parameter int FRAME_CLKS = 833333,
	parameter int TONE_DIV = 50
) (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_addr_t paddr,
	input apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pslverr,
	output logic audio_out,
	output logic sound_en
);

	sfx_event_if ev_bus ();

	sound_pkg::freq_t freq;
	logic frame_tick;
	logic mute;

	apb_sound_regs u_regs (
		.clk(clk),
		.resetN(resetN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pslverr(pslverr),
		.ev(ev_bus.source),
		.freq(freq),
		.sound_en(sound_en),
		.mute(mute)
	);

	sound_machine u_seq (
		.clk(clk),
		.resetN(resetN),
		.frame_tick(frame_tick),
		.ev(ev_bus.sink),
		.freq(freq),
		.sound_en(sound_en)
	);

	frame_timer #(.FRAME_CLKS(FRAME_CLKS)) u_frame (
		.clk(clk),
		.resetN(resetN),
		.frame_tick(frame_tick)
	);

	tone_gen #(.TONE_DIV(TONE_DIV)) u_tone (
		.clk(clk),
		.resetN(resetN),
		.freq(freq),
		.sound_en(sound_en),
		.mute(mute),
		.audio_out(audio_out)
	);

endmodule

//--- testbench/sound_checker.sv
module sound_checker (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic audio_out,
	input logic sound_en
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_errors = 0;

	a_err_in_access: assert property (@(posedge clk) disable iff (!resetN)
		pslverr |-> (psel && penable))
		else begin
			assert_errors++;
			$error("pslverr high outside an access cycle");
		end

	// audio_out is registered, so it follows sound_en one edge later.
	a_quiet_when_idle: assert property (@(posedge clk) disable iff (!resetN)
		!$past(sound_en) |-> !audio_out)
		else begin
			assert_errors++;
			$error("audio_out high after sound_en was low");
		end

	a_idle_after_reset: assert property (@(posedge clk) $rose(resetN) |-> !sound_en)
		else begin
			assert_errors++;
			$error("sound_en high right after reset release");
		end

endmodule

bind sound_top sound_checker u_checker (
	.clk(clk),
	.resetN(resetN),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.audio_out(audio_out),
	.sound_en(sound_en)
);

//--- testbench/tb_sound.sv
module tb_sound;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 20 * 3 * 132 + 2000;
	// notes per event, in trigger bit order.
	localparam logic [9:0] NOTES [5][3] = '{
		'{10'h250, 10'h2EA, 10'h00F},
		'{10'h1F2, 10'h250, 10'h1BB},
		'{10'h20F, 10'h1D6, 10'h18B},
		'{10'h00F, 10'h00F, 10'h00F},
		'{10'h2EA, 10'h1F2, 10'h00F}
	};

	logic clk;
	logic resetN;
	logic psel;
	logic penable;
	logic pwrite;
	apb_pkg::apb_addr_t paddr;
	apb_pkg::apb_data_t pwdata;
	apb_pkg::apb_data_t prdata;
	logic pslverr;
	logic audio_out;
	logic sound_en;
	int errors = 0;
	int cyc_count = 0;

	sound_top #(.FRAME_CLKS(4), .TONE_DIV(2)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
		end
	endtask

	task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
		output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
	endtask

	task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t wdata,
		output apb_pkg::apb_data_t data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0; // no repeated write.
		penable <= 1'b0;
	endtask

	task automatic bus_idle();
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_idle();
		apb_pkg::apb_data_t data;
		logic err;
		do apb_read(apb_pkg::ADDR_STATUS, data, err); while (data[0]);
		bus_idle();
	endtask

	function automatic int first_event(input logic [4:0] bits);
		for (int i = 0; i < 5; i++) begin
			if (bits[i]) return i;
		end
		return 0;
	endfunction

	task automatic measure_half(output int cycles);
		logic prev;
		int t0;
		int guard;
		guard = 0;
		@(negedge clk);
		prev = audio_out;
		while (audio_out == prev && guard < 200) begin
			@(negedge clk);
			guard++;
		end
		t0 = cyc_count;
		prev = audio_out;
		while (audio_out == prev && guard < 200) begin
			@(negedge clk);
			guard++;
		end
		cycles = cyc_count - t0;
		if (guard >= 200) begin
			errors++;
			$display("audio_out stopped toggling while a note was playing");
		end
	endtask

	task automatic test_registers();
		apb_pkg::apb_data_t data;
		logic err;
		apb_read(apb_pkg::ADDR_STATUS, data, err);
		check(data, 0, "status after reset");
		check(err, 0, "pslverr on status read");
		apb_read(apb_pkg::ADDR_CTRL, data, err);
		check(data, 0, "ctrl after reset");
		apb_write(apb_pkg::ADDR_CTRL, 32'h1, data, err);
		check(err, 0, "pslverr on ctrl write");
		apb_read(apb_pkg::ADDR_CTRL, data, err);
		check(data, 1, "ctrl readback of mute");
		apb_write(apb_pkg::ADDR_CTRL, 32'h0, data, err);
		apb_read(apb_pkg::ADDR_CTRL, data, err);
		check(data, 0, "ctrl readback after clear");
		apb_read(apb_pkg::ADDR_TRIG, data, err);
		check(err, 1, "pslverr on trig read");
		apb_write(apb_pkg::ADDR_STATUS, 32'h1, data, err);
		check(err, 1, "pslverr on status write");
		apb_read(8'h10, data, err);
		check(err, 1, "pslverr on unmapped read");
		apb_write(8'h10, 32'h1F, data, err);
		check(err, 1, "pslverr on unmapped write");
		repeat (4) @(negedge clk);
		check(sound_en, 0, "no sound from unmapped write");
	endtask

	task automatic play_effect(input int ev);
		apb_pkg::apb_data_t data;
		logic err;
		logic [9:0] codes[$];
		logic [9:0] expect_codes[$];
		int t_start;
		int t_end;
		t_start = -1;
		t_end = -1;
		for (int n = 0; n < 3; n++) begin
			if (n == 0 || NOTES[ev][n] != NOTES[ev][n-1]) expect_codes.push_back(NOTES[ev][n]);
		end
		apb_write(apb_pkg::ADDR_TRIG, 32'(1) << ev, data, err);
		while (t_end < 0) begin
			apb_read(apb_pkg::ADDR_STATUS, data, err);
			if (data[0] && t_start < 0) t_start = cyc_count;
			if (!data[0] && t_start >= 0) t_end = cyc_count;
			if (data[25:16] != 0 && (codes.size() == 0 || codes[$] != data[25:16])) begin
				codes.push_back(data[25:16]);
			end
		end
		bus_idle();
		check(codes.size(), expect_codes.size(), $sformatf("distinct notes of event %0d", ev));
		foreach (expect_codes[i]) begin
			if (i < codes.size()) check(codes[i], expect_codes[i], "note code in sequence");
		end
		check((t_end - t_start >= 3 * 128) && (t_end - t_start <= 3 * 132 + 2), 1,
			$sformatf("playing time %0d cycles in range", t_end - t_start));
		check(sound_en, 0, "sound_en after effect");
	endtask

	task automatic test_priority();
		apb_pkg::apb_data_t data;
		logic err;
		logic [4:0] bits;
		repeat (6) begin
			bits = 5'($urandom_range(1, 31));
			repeat ($urandom_range(0, 7)) @(posedge clk);
			apb_write(apb_pkg::ADDR_TRIG, 32'(bits), data, err);
			do apb_read(apb_pkg::ADDR_STATUS, data, err); while (!data[0]);
			bus_idle();
			check(data[25:16], NOTES[first_event(bits)][0], $sformatf("first note for %b", bits));
			wait_idle();
		end
	endtask

	task automatic test_restart();
		apb_pkg::apb_data_t data;
		logic err;
		apb_write(apb_pkg::ADDR_TRIG, 32'h10, data, err);
		do apb_read(apb_pkg::ADDR_STATUS, data, err); while (data[25:16] != NOTES[4][0]);
		bus_idle();
		repeat ($urandom_range(10, 100)) @(posedge clk); // stays inside note 1.
		apb_write(apb_pkg::ADDR_TRIG, 32'h01, data, err);
		do apb_read(apb_pkg::ADDR_STATUS, data, err); while (data[25:16] == NOTES[4][0]);
		bus_idle();
		check(data[25:16], NOTES[0][0], "note after pending player_hit");
		wait_idle();
	endtask

	task automatic test_tone_mute();
		apb_pkg::apb_data_t data;
		logic err;
		int half;
		apb_write(apb_pkg::ADDR_TRIG, 32'h08, data, err);
		do apb_read(apb_pkg::ADDR_STATUS, data, err); while (!data[0]);
		bus_idle();
		check(data[25:16], NOTES[3][0], "note code of level up");
		measure_half(half);
		check(half, NOTES[3][0] * 2, "half period of audio_out");
		apb_write(apb_pkg::ADDR_CTRL, 32'h1, data, err);
		@(posedge clk); // audio_out clears one edge after mute.
		repeat (60) begin
			@(negedge clk);
			check(audio_out, 0, "audio_out while muted");
			check(sound_en, 1, "sound_en while muted");
		end
		apb_write(apb_pkg::ADDR_CTRL, 32'h0, data, err);
		measure_half(half);
		check(half, NOTES[3][0] * 2, "half period after unmute");
		wait_idle();
	endtask

	initial begin
		while (cyc_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cyc_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hf50e));
		resetN <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		repeat (3) @(posedge clk);
		resetN <= 1'b1;
		test_registers();
		for (int ev = 0; ev < 5; ev++) play_effect(ev);
		test_priority();
		test_restart();
		test_tone_mute();
		$display("summary: %0d check errors, %0d assertion failures", errors,
			u_dut.u_checker.assert_errors);
		if (errors == 0 && u_dut.u_checker.assert_errors == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- files.f
common/sound_pkg.sv
common/apb_pkg.sv
common/sfx_event_if.sv
hw/apb_sound_regs.sv
sound_machine/sound_machine.sv
hw/frame_timer.sv
hw/tone_gen.sv
hw/sound_top.sv
testbench/sound_checker.sv
testbench/tb_sound.sv
